// ==== avr_core.f ====
design/avr_pkg.sv
design/avr_decoder.sv
design/avr_regfile.sv
design/avr_alu.sv
design/avr_data_port.sv
design/avr_core.sv
testbench/avr_core_tb.sv

// ==== design/avr_alu.sv ====
`timescale 1ns/100ps

module avr_alu (
    input  avr_pkg::alu_op_t   op_i,
    input  avr_pkg::reg_data_t a_i,
    input  avr_pkg::reg_data_t b_i,
    input  avr_pkg::sreg_t     sreg_i,
    output avr_pkg::reg_data_t result_o,
    output avr_pkg::sreg_t     sreg_o
);

    logic               carry_in;
    logic [8:0]         sum_w;
    logic [8:0]         diff_w;   // Bit 8 is the borrow
    avr_pkg::reg_data_t res;
    avr_pkg::sreg_t     flags;

    assign carry_in = (op_i == avr_pkg::ALU_ADC || op_i == avr_pkg::ALU_SBC) ?
                      sreg_i[avr_pkg::SREG_C] : 1'b0;

    assign sum_w  = {1'b0, a_i} + {1'b0, b_i} + {8'd0, carry_in};
    assign diff_w = {1'b0, a_i} - {1'b0, b_i} - {8'd0, carry_in};

    // ------------------------------------------------------------------------
    // Result and per-class flags
    // ------------------------------------------------------------------------

    always_comb begin
        res   = b_i;
        flags = sreg_i;

        case (op_i)
            avr_pkg::ALU_ADD,
            avr_pkg::ALU_ADC: begin
                res = sum_w[7:0];
                flags[avr_pkg::SREG_C] = sum_w[8];
                flags[avr_pkg::SREG_H] = (a_i[3] & b_i[3]) | (b_i[3] & ~res[3]) |
                                         (~res[3] & a_i[3]);
                flags[avr_pkg::SREG_V] = (a_i[7] & b_i[7] & ~res[7]) |
                                         (~a_i[7] & ~b_i[7] & res[7]);
            end
            avr_pkg::ALU_SUB,
            avr_pkg::ALU_SBC: begin
                res = diff_w[7:0];
                flags[avr_pkg::SREG_C] = diff_w[8];
                flags[avr_pkg::SREG_H] = (~a_i[3] & b_i[3]) | (b_i[3] & res[3]) |
                                         (res[3] & ~a_i[3]);
                flags[avr_pkg::SREG_V] = (a_i[7] & ~b_i[7] & ~res[7]) |
                                         (~a_i[7] & b_i[7] & res[7]);
            end
            avr_pkg::ALU_AND: res = a_i & b_i;
            avr_pkg::ALU_OR:  res = a_i | b_i;
            avr_pkg::ALU_EOR: res = a_i ^ b_i;
            default:          res = b_i;
        endcase

        // Logic ops keep C and H
        if (op_i inside {avr_pkg::ALU_AND, avr_pkg::ALU_OR, avr_pkg::ALU_EOR})
            flags[avr_pkg::SREG_V] = 1'b0;

        // Common N, S, Z except on pass-through
        if (op_i != avr_pkg::ALU_PASS) begin
            flags[avr_pkg::SREG_N] = res[7];
            flags[avr_pkg::SREG_S] = res[7] ^ flags[avr_pkg::SREG_V];
            flags[avr_pkg::SREG_Z] = (res == 8'h00) &&
                                     (op_i != avr_pkg::ALU_SBC || sreg_i[avr_pkg::SREG_Z]);
        end
    end

    assign result_o = res;
    assign sreg_o   = flags;

endmodule

// ==== design/avr_core.sv ====
`timescale 1ns/100ps

module avr_core #(
    parameter avr_pkg::pc_t RESET_VECTOR = 16'h0000
) (
    input  logic                clock_i,
    input  logic                reset_n_i,
    output avr_pkg::pc_t        pc_o,
    input  avr_pkg::instr_t     instr_i,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output avr_pkg::data_addr_t mem_addr_o,
    output avr_pkg::reg_data_t  mem_wdata_o,
    input  logic                mem_ack_i,
    input  avr_pkg::reg_data_t  mem_rdata_i
);

    typedef enum logic {
        CORE_EXECUTE,
        CORE_MEM_WAIT
    } core_state_t;

    core_state_t           state_q;
    avr_pkg::pc_t          pc_q;
    avr_pkg::pc_t          pc_plus1;
    avr_pkg::pc_t          pc_next;

    avr_pkg::instr_kind_t  kind;
    avr_pkg::alu_op_t      alu_op;
    avr_pkg::reg_idx_t     rd;
    avr_pkg::reg_idx_t     rr;
    avr_pkg::reg_data_t    imm;
    logic                  use_imm;
    logic                  dec_reg_we;
    logic                  dec_sreg_we;
    logic [2:0]            branch_bit;
    logic                  branch_set;
    avr_pkg::pc_t          offset;
    logic                  post_inc;

    avr_pkg::reg_data_t    rd_data;
    avr_pkg::reg_data_t    rr_data;
    avr_pkg::data_addr_t   x_ptr;
    avr_pkg::sreg_t        sreg;
    avr_pkg::reg_data_t    alu_result;
    avr_pkg::sreg_t        alu_sreg;
    avr_pkg::reg_data_t    load_data;
    logic                  port_done;

    logic                  is_mem;
    logic                  exec_alu;
    logic                  mem_finish;

    assign is_mem     = (kind == avr_pkg::KIND_LOAD) || (kind == avr_pkg::KIND_STORE);
    assign exec_alu   = (state_q == CORE_EXECUTE) && (kind == avr_pkg::KIND_ALU);
    assign mem_finish = (state_q == CORE_MEM_WAIT) && port_done;

    avr_decoder decoder_i (
        .instr_i      (instr_i),
        .kind_o       (kind),
        .alu_op_o     (alu_op),
        .rd_o         (rd),
        .rr_o         (rr),
        .imm_o        (imm),
        .use_imm_o    (use_imm),
        .reg_we_o     (dec_reg_we),
        .sreg_we_o    (dec_sreg_we),
        .branch_bit_o (branch_bit),
        .branch_set_o (branch_set),
        .offset_o     (offset),
        .post_inc_o   (post_inc)
    );

    // Load data lands in rd on the done cycle
    avr_regfile regfile_i (
        .clock_i   (clock_i),
        .reset_n_i (reset_n_i),
        .rd_idx_i  (rd),
        .rr_idx_i  (rr),
        .we_i      (dec_reg_we && (exec_alu || mem_finish)),
        .wdata_i   ((kind == avr_pkg::KIND_LOAD) ? load_data : alu_result),
        .sreg_we_i (dec_sreg_we && exec_alu),
        .sreg_i    (alu_sreg),
        .x_inc_i   (post_inc && mem_finish),
        .rd_data_o (rd_data),
        .rr_data_o (rr_data),
        .x_o       (x_ptr),
        .sreg_o    (sreg)
    );

    avr_alu alu_i (
        .op_i     (alu_op),
        .a_i      (rd_data),
        .b_i      (use_imm ? imm : rr_data),
        .sreg_i   (sreg),
        .result_o (alu_result),
        .sreg_o   (alu_sreg)
    );

    avr_data_port data_port_i (
        .clock_i     (clock_i),
        .reset_n_i   (reset_n_i),
        .start_i     ((state_q == CORE_EXECUTE) && is_mem),
        .we_i        (kind == avr_pkg::KIND_STORE),
        .addr_i      (x_ptr),
        .wdata_i     (rd_data),   // ST source register sits in the rd field
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .rdata_o     (load_data),
        .done_o      (port_done)
    );

    // ------------------------------------------------------------------------
    // Program counter and sequencing
    // ------------------------------------------------------------------------

    assign pc_plus1 = pc_q + 16'd1;

    always_comb begin
        case (kind)
            avr_pkg::KIND_JUMP:   pc_next = pc_plus1 + offset;
            avr_pkg::KIND_BRANCH: pc_next = (sreg[branch_bit] == branch_set) ?
                                            pc_plus1 + offset : pc_plus1;
            default:              pc_next = pc_plus1;
        endcase
    end

    always_ff @(posedge clock_i) begin
        if (!reset_n_i) begin
            pc_q    <= RESET_VECTOR;
            state_q <= CORE_EXECUTE;
        end else begin
            case (state_q)
                CORE_EXECUTE: begin
                    if (is_mem)
                        state_q <= CORE_MEM_WAIT;   // Hold pc for the transfer
                    else
                        pc_q <= pc_next;
                end
                CORE_MEM_WAIT: begin
                    if (port_done) begin
                        pc_q    <= pc_plus1;
                        state_q <= CORE_EXECUTE;
                    end
                end
                default: state_q <= CORE_EXECUTE;
            endcase
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== design/avr_data_port.sv ====
`timescale 1ns/100ps

module avr_data_port (
    input  logic                clock_i,
    input  logic                reset_n_i,
    input  logic                start_i,
    input  logic                we_i,
    input  avr_pkg::data_addr_t addr_i,
    input  avr_pkg::reg_data_t  wdata_i,
    input  logic                mem_ack_i,
    input  avr_pkg::reg_data_t  mem_rdata_i,
    output logic                mem_req_o,
    output logic                mem_we_o,
    output avr_pkg::data_addr_t mem_addr_o,
    output avr_pkg::reg_data_t  mem_wdata_o,
    output avr_pkg::reg_data_t  rdata_o,
    output logic                done_o
);

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_REQ,       // Req high, waiting for ack
        PORT_RELEASE    // Req dropped, waiting for ack low
    } port_state_t;

    port_state_t         state_q;
    logic                we_q;
    logic                done_q;
    avr_pkg::data_addr_t addr_q;
    avr_pkg::reg_data_t  wdata_q;
    avr_pkg::reg_data_t  rdata_q;

    // ------------------------------------------------------------------------
    // Four-phase handshake
    // ------------------------------------------------------------------------

    always_ff @(posedge clock_i) begin
        if (!reset_n_i) begin
            state_q <= PORT_IDLE;
            we_q    <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                PORT_IDLE: begin
                    if (start_i) begin
                        we_q    <= we_i;
                        state_q <= PORT_REQ;
                    end
                end
                PORT_REQ: begin
                    if (mem_ack_i)
                        state_q <= PORT_RELEASE;
                end
                PORT_RELEASE: begin
                    if (!mem_ack_i) begin
                        done_q  <= 1'b1;   // Memory has let go
                        state_q <= PORT_IDLE;
                    end
                end
                default: state_q <= PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (state_q == PORT_IDLE && start_i) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
        if (state_q == PORT_REQ && mem_ack_i && !we_q)
            rdata_q <= mem_rdata_i;   // Valid only while ack is high
    end

    assign mem_req_o   = (state_q == PORT_REQ);
    assign mem_we_o    = we_q;
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;
    assign rdata_o     = rdata_q;
    assign done_o      = done_q;

endmodule

// ==== design/avr_decoder.sv ====
`timescale 1ns/100ps

module avr_decoder (
    input  avr_pkg::instr_t      instr_i,
    output avr_pkg::instr_kind_t kind_o,
    output avr_pkg::alu_op_t     alu_op_o,
    output avr_pkg::reg_idx_t    rd_o,
    output avr_pkg::reg_idx_t    rr_o,
    output avr_pkg::reg_data_t   imm_o,
    output logic                 use_imm_o,
    output logic                 reg_we_o,
    output logic                 sreg_we_o,
    output logic [2:0]           branch_bit_o,
    output logic                 branch_set_o,
    output avr_pkg::pc_t         offset_o,
    output logic                 post_inc_o
);

    // Operation select from the opcode prefix
    always_comb begin
        alu_op_o = avr_pkg::ALU_PASS;   // MOV, LDI
        casez (instr_i[15:10])
            6'b0000_01: alu_op_o = avr_pkg::ALU_SBC;   // CPC
            6'b0000_10: alu_op_o = avr_pkg::ALU_SBC;
            6'b0000_11: alu_op_o = avr_pkg::ALU_ADD;
            6'b0001_01: alu_op_o = avr_pkg::ALU_SUB;   // CP
            6'b0001_10: alu_op_o = avr_pkg::ALU_SUB;
            6'b0001_11: alu_op_o = avr_pkg::ALU_ADC;
            6'b0010_00: alu_op_o = avr_pkg::ALU_AND;
            6'b0010_01: alu_op_o = avr_pkg::ALU_EOR;
            6'b0010_10: alu_op_o = avr_pkg::ALU_OR;
            6'b0011_??: alu_op_o = avr_pkg::ALU_SUB;   // CPI
            6'b0100_??: alu_op_o = avr_pkg::ALU_SBC;   // SBCI
            6'b0101_??: alu_op_o = avr_pkg::ALU_SUB;   // SUBI
            6'b0110_??: alu_op_o = avr_pkg::ALU_OR;    // ORI
            6'b0111_??: alu_op_o = avr_pkg::ALU_AND;   // ANDI
            default:    alu_op_o = avr_pkg::ALU_PASS;
        endcase
    end

    // ------------------------------------------------------------------------
    // Instruction class and operand fields
    // ------------------------------------------------------------------------

    always_comb begin
        kind_o       = avr_pkg::KIND_NOP;
        rd_o         = instr_i[8:4];
        rr_o         = {instr_i[9], instr_i[3:0]};
        imm_o        = {instr_i[11:8], instr_i[3:0]};
        use_imm_o    = 1'b0;
        reg_we_o     = 1'b0;
        sreg_we_o    = 1'b0;
        branch_bit_o = instr_i[2:0];
        branch_set_o = ~instr_i[10];   // BRBS has bit 10 clear
        offset_o     = '0;
        post_inc_o   = 1'b0;

        casez (instr_i)
            // NOP, MOVW, multiplies and CPSE fall through as NOP
            16'b000?_00??_????_????: kind_o = avr_pkg::KIND_NOP;

            // Two-register group
            16'b000?_????_????_????,
            16'b0010_????_????_????: begin
                kind_o    = avr_pkg::KIND_ALU;
                reg_we_o  = (instr_i[13:10] != 4'b0001) && (instr_i[13:10] != 4'b0101);
                sreg_we_o = (instr_i[13:10] != 4'b1011);   // MOV leaves flags
            end

            // Immediate group works on r16..r31
            16'b0011_????_????_????,
            16'b01??_????_????_????: begin
                kind_o    = avr_pkg::KIND_ALU;
                rd_o      = {1'b1, instr_i[7:4]};
                use_imm_o = 1'b1;
                reg_we_o  = (instr_i[15:12] != 4'b0011);   // CPI only compares
                sreg_we_o = 1'b1;
            end

            16'b1110_????_????_????: begin   // LDI
                kind_o    = avr_pkg::KIND_ALU;
                rd_o      = {1'b1, instr_i[7:4]};
                use_imm_o = 1'b1;
                reg_we_o  = 1'b1;
            end

            16'b1100_????_????_????: begin   // RJMP
                kind_o   = avr_pkg::KIND_JUMP;
                offset_o = {{4{instr_i[11]}}, instr_i[11:0]};
            end

            16'b1111_0???_????_????: begin   // BRBS / BRBC
                kind_o   = avr_pkg::KIND_BRANCH;
                offset_o = {{9{instr_i[9]}}, instr_i[9:3]};
            end

            // LD / ST through X, bit 0 selects post-increment
            16'b1001_00??_????_110?: begin
                kind_o     = instr_i[9] ? avr_pkg::KIND_STORE : avr_pkg::KIND_LOAD;
                reg_we_o   = ~instr_i[9];
                post_inc_o = instr_i[0];
            end

            default: kind_o = avr_pkg::KIND_NOP;
        endcase
    end

endmodule

// ==== design/avr_pkg.sv ====
package avr_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    typedef logic [15:0] instr_t;       // One program word
    typedef logic [15:0] pc_t;          // Program word address
    typedef logic [15:0] data_addr_t;   // Data memory byte address
    typedef logic [7:0]  reg_data_t;    // Register or memory byte
    typedef logic [4:0]  reg_idx_t;     // r0..r31
    typedef logic [7:0]  sreg_t;

    // ------------------------------------------------------------------------
    // Operation classes
    // ------------------------------------------------------------------------

    typedef enum logic [3:0] {
        ALU_PASS,   // Result is operand B
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_OR,
        ALU_EOR
    } alu_op_t;

    typedef enum logic [2:0] {
        KIND_NOP,
        KIND_ALU,       // Includes LDI and MOV
        KIND_JUMP,
        KIND_BRANCH,
        KIND_LOAD,
        KIND_STORE
    } instr_kind_t;

    // ------------------------------------------------------------------------
    // SREG bit positions
    // ------------------------------------------------------------------------

    localparam int SREG_C = 0;
    localparam int SREG_Z = 1;
    localparam int SREG_N = 2;
    localparam int SREG_V = 3;
    localparam int SREG_S = 4;
    localparam int SREG_H = 5;   // T and I above stay at zero

    // X pointer pair
    localparam reg_idx_t X_LO_IDX = 5'd26;
    localparam reg_idx_t X_HI_IDX = 5'd27;

endpackage

// ==== design/avr_regfile.sv ====
`timescale 1ns/100ps

module avr_regfile (
    input  logic               clock_i,
    input  logic               reset_n_i,
    input  avr_pkg::reg_idx_t  rd_idx_i,
    input  avr_pkg::reg_idx_t  rr_idx_i,
    input  logic               we_i,
    input  avr_pkg::reg_data_t wdata_i,
    input  logic               sreg_we_i,
    input  avr_pkg::sreg_t     sreg_i,
    input  logic               x_inc_i,
    output avr_pkg::reg_data_t rd_data_o,
    output avr_pkg::reg_data_t rr_data_o,
    output avr_pkg::data_addr_t x_o,
    output avr_pkg::sreg_t     sreg_o
);

    avr_pkg::reg_data_t  regs_q [32];
    avr_pkg::sreg_t      sreg_q;
    avr_pkg::data_addr_t x_next;

    assign x_o    = {regs_q[avr_pkg::X_HI_IDX], regs_q[avr_pkg::X_LO_IDX]};
    assign x_next = x_o + 16'd1;   // Carry crosses into r27

    always_ff @(posedge clock_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < 32; i++)
                regs_q[i] <= '0;
            sreg_q <= '0;
        end else begin
            if (x_inc_i) begin
                regs_q[avr_pkg::X_LO_IDX] <= x_next[7:0];
                regs_q[avr_pkg::X_HI_IDX] <= x_next[15:8];
            end
            // Later assignment wins, so a load into r26/r27 beats the increment
            if (we_i)
                regs_q[rd_idx_i] <= wdata_i;
            if (sreg_we_i)
                sreg_q <= {2'b00, sreg_i[avr_pkg::SREG_H:avr_pkg::SREG_C]};   // T, I held low
        end
    end

    assign rd_data_o = regs_q[rd_idx_i];
    assign rr_data_o = regs_q[rr_idx_i];
    assign sreg_o    = sreg_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the avr_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f avr_core.f --top-module avr_core_tb -o avr_core_sim; then
    echo "Verilator compile failed"
    exit 1
fi

if ! ./obj_dir/avr_core_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation run returned an error status"
    exit 1
fi

cat "$LOG"

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
else
    exit 1
fi

// ==== testbench/avr_core_tb.sv ====
`timescale 1ns/100ps

module avr_core_tb;

    localparam avr_pkg::pc_t RESET_VECTOR = 16'h0010;

    logic                clock;
    logic                reset_n;
    avr_pkg::pc_t        pc_o;
    avr_pkg::instr_t     instr_i;
    logic                mem_req_o;
    logic                mem_we_o;
    avr_pkg::data_addr_t mem_addr_o;
    avr_pkg::reg_data_t  mem_wdata_o;
    logic                mem_ack_i;
    avr_pkg::reg_data_t  mem_rdata_i;

    avr_pkg::instr_t     rom [256];
    avr_pkg::reg_data_t  data_mem [65536];
    int                  emit_pos;
    int                  resp_state;
    int                  resp_cnt;
    avr_pkg::data_addr_t exp_addr [$];
    avr_pkg::reg_data_t  exp_data [$];
    avr_pkg::data_addr_t obs_addr [$];
    avr_pkg::reg_data_t  obs_data [$];

    avr_core #(.RESET_VECTOR(RESET_VECTOR)) dut_i (
        .clock_i     (clock),
        .reset_n_i   (reset_n),
        .pc_o        (pc_o),
        .instr_i     (instr_i),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    assign instr_i = rom[pc_o[7:0]];   // Program memory answers in the same cycle

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------------

    function automatic avr_pkg::instr_t enc_ldi(input logic [4:0] d, input logic [7:0] k);
        return {4'hE, k[7:4], d[3:0], k[3:0]};
    endfunction

    function automatic avr_pkg::instr_t enc_rr(input logic [5:0] op, input logic [4:0] d,
                                               input logic [4:0] r);
        return {op, r[4], d, r[3:0]};
    endfunction

    function automatic avr_pkg::instr_t enc_imm(input logic [3:0] op, input logic [4:0] d,
                                                input logic [7:0] k);
        return {op, k[7:4], d[3:0], k[3:0]};
    endfunction

    function automatic avr_pkg::instr_t enc_rjmp(input logic [11:0] k);
        return {4'hC, k};
    endfunction

    function automatic avr_pkg::instr_t enc_br(input logic clr, input logic [2:0] s,
                                               input logic [6:0] k);
        return {5'b11110, clr, k, s};
    endfunction

    function automatic avr_pkg::instr_t enc_mem(input logic st, input logic [4:0] r,
                                                input logic inc);
        return {6'b100100, st, r, 3'b110, inc};
    endfunction

    task automatic emit(input avr_pkg::instr_t w);
        rom[emit_pos] = w;
        emit_pos++;
    endtask

    // ------------------------------------------------------------------------
    // ISA reference model
    // ------------------------------------------------------------------------

    // Bits 0..5 are C, Z, N, V, S, H
    function automatic avr_pkg::sreg_t arith(input logic sub, input logic [7:0] a,
                                             input logic [7:0] b, input logic cin,
                                             input logic chain_z, input avr_pkg::sreg_t s_in,
                                             output logic [7:0] r);
        logic [8:0]     full;
        logic [4:0]     nib;
        avr_pkg::sreg_t s;
        s = s_in;
        if (sub) begin
            full = {1'b0, a} - {1'b0, b} - {8'd0, cin};
            nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
        end else begin
            full = {1'b0, a} + {1'b0, b} + {8'd0, cin};
            nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
        end
        r    = full[7:0];
        s[0] = full[8];
        s[5] = nib[4];   // Carry or borrow out of bit 3
        // Signed overflow from operand and result signs
        if (sub)
            s[3] = (a[7] != b[7]) && (r[7] != a[7]);
        else
            s[3] = (a[7] == b[7]) && (r[7] != a[7]);
        s[2] = r[7];
        s[4] = s[2] ^ s[3];
        if (chain_z)
            s[1] = s_in[1] && (r == 8'h00);   // Zero only if it was zero before
        else
            s[1] = (r == 8'h00);
        return s;
    endfunction

    function automatic avr_pkg::sreg_t logic_op(input logic [7:0] v, input avr_pkg::sreg_t s_in,
                                                output logic [7:0] r);
        avr_pkg::sreg_t s;
        s = s_in;
        r = v;
        s[3] = 1'b0;
        s[2] = v[7];
        s[4] = v[7];
        s[1] = (v == 8'h00);
        return s;
    endfunction

    function automatic void run_model();
        logic [7:0]      r [32];
        avr_pkg::sreg_t  s;
        avr_pkg::pc_t    pc;
        avr_pkg::instr_t w;
        logic [7:0]      a;
        logic [7:0]      b;
        logic [7:0]      res;
        logic [4:0]      d;
        logic [15:0]     x;
        logic            wr;
        for (int i = 0; i < 32; i++)
            r[i] = 8'h00;
        s  = '0;
        pc = RESET_VECTOR;
        for (int step = 0; step < 1000; step++) begin
            w  = rom[pc[7:0]];
            pc = pc + 16'd1;
            if (w == enc_rjmp(12'hFFF))
                break;   // Idle loop reached
            if (w[15:12] == 4'hE) begin
                r[{1'b1, w[7:4]}] = {w[11:8], w[3:0]};
            end else if (w[15:12] >= 4'h3 && w[15:12] <= 4'h7) begin
                d = {1'b1, w[7:4]};
                a = r[d];
                b = {w[11:8], w[3:0]};
                case (w[15:12])
                    4'h3, 4'h5: s = arith(1'b1, a, b, 1'b0, 1'b0, s, res);
                    4'h4:       s = arith(1'b1, a, b, s[0], 1'b1, s, res);
                    4'h6:       s = logic_op(a | b, s, res);
                    default:    s = logic_op(a & b, s, res);
                endcase
                if (w[15:12] != 4'h3)
                    r[d] = res;
            end else if (w[15:14] == 2'b00) begin
                d  = w[8:4];
                a  = r[d];
                b  = r[{w[9], w[3:0]}];
                wr = 1'b1;
                case (w[15:10])
                    6'b000011: s = arith(1'b0, a, b, 1'b0, 1'b0, s, res);   // ADD
                    6'b000111: s = arith(1'b0, a, b, s[0], 1'b0, s, res);   // ADC
                    6'b000110: s = arith(1'b1, a, b, 1'b0, 1'b0, s, res);   // SUB
                    6'b000010: s = arith(1'b1, a, b, s[0], 1'b1, s, res);   // SBC
                    6'b000101: begin
                        s  = arith(1'b1, a, b, 1'b0, 1'b0, s, res);
                        wr = 1'b0;
                    end
                    6'b000001: begin
                        s  = arith(1'b1, a, b, s[0], 1'b1, s, res);
                        wr = 1'b0;
                    end
                    6'b001000: s = logic_op(a & b, s, res);
                    6'b001001: s = logic_op(a ^ b, s, res);
                    6'b001010: s = logic_op(a | b, s, res);
                    6'b001011: res = b;   // MOV
                    default:   wr = 1'b0;
                endcase
                if (wr)
                    r[d] = res;
            end else if (w[15:12] == 4'hC) begin
                pc = pc + {{4{w[11]}}, w[11:0]};
            end else if (w[15:11] == 5'b11110) begin
                if (s[w[2:0]] == !w[10])
                    pc = pc + {{9{w[9]}}, w[9:3]};
            end else if (w[15:10] == 6'b100100 && w[3:1] == 3'b110) begin
                x = {r[27], r[26]};
                if (w[9]) begin
                    exp_addr.push_back(x);
                    exp_data.push_back(r[w[8:4]]);
                end else begin
                    r[w[8:4]] = data_mem[x];
                end
                if (w[0]) begin
                    x = x + 16'd1;
                    r[26] = x[7:0];
                    r[27] = x[15:8];
                end
            end
        end
    endfunction

    // ------------------------------------------------------------------------
    // Checks and data memory responder
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    initial begin
        void'($urandom(48757));
        forever begin
            @(negedge clock);
            if (resp_state == 0 && mem_req_o) begin
                resp_cnt   = $urandom_range(5, 0);
                resp_state = 1;
            end
            if (resp_state == 1) begin
                if (resp_cnt == 0) begin
                    if (mem_we_o) begin
                        data_mem[mem_addr_o] = mem_wdata_o;
                        obs_addr.push_back(mem_addr_o);
                        obs_data.push_back(mem_wdata_o);
                    end else begin
                        mem_rdata_i = data_mem[mem_addr_o];
                    end
                    mem_ack_i  = 1'b1;
                    resp_state = 2;
                end else begin
                    resp_cnt--;
                end
            end else if (resp_state == 2 && !mem_req_o) begin
                resp_cnt   = $urandom_range(5, 0);
                resp_state = 3;
            end
            if (resp_state == 3) begin
                if (resp_cnt == 0) begin
                    mem_ack_i  = 1'b0;
                    resp_state = 0;
                end else begin
                    resp_cnt--;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Program, reset and compare
    // ------------------------------------------------------------------------

    task automatic build_program();
        emit_pos = int'(RESET_VECTOR);
        emit(enc_ldi(5'd26, 8'h40));
        emit(enc_ldi(5'd27, 8'h01));                 // X = 0x0140
        emit(enc_ldi(5'd16, 8'hA5));
        emit(enc_rr(6'b001011, 5'd1, 5'd16));        // MOV r1, r16
        emit(enc_mem(1'b1, 5'd16, 1'b1));
        emit(enc_mem(1'b1, 5'd1, 1'b1));
        emit(enc_ldi(5'd17, 8'hF0));
        emit(enc_ldi(5'd18, 8'h35));
        emit(enc_rr(6'b000011, 5'd17, 5'd18));       // ADD sets C
        emit(enc_rr(6'b000111, 5'd18, 5'd17));       // ADC
        emit(enc_rr(6'b000110, 5'd18, 5'd16));       // SUB borrows
        emit(enc_rr(6'b000010, 5'd17, 5'd16));       // SBC
        emit(enc_mem(1'b1, 5'd17, 1'b1));
        emit(enc_mem(1'b1, 5'd18, 1'b1));
        emit(enc_rr(6'b001000, 5'd17, 5'd16));       // AND
        emit(enc_rr(6'b001010, 5'd18, 5'd16));       // OR
        emit(enc_rr(6'b001001, 5'd1, 5'd17));        // EOR
        emit(enc_mem(1'b1, 5'd1, 1'b1));
        emit(enc_ldi(5'd19, 8'hEE));                 // Marker
        emit(enc_rr(6'b000101, 5'd16, 5'd18));       // CP
        emit(enc_br(1'b1, 3'd0, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_rr(6'b000001, 5'd18, 5'd16));       // CPC
        emit(enc_br(1'b0, 3'd1, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_imm(4'h3, 5'd16, 8'hA5));           // CPI
        emit(enc_br(1'b1, 3'd1, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_imm(4'h5, 5'd18, 8'h10));           // SUBI
        emit(enc_br(1'b0, 3'd2, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_imm(4'h4, 5'd17, 8'h80));           // SBCI
        emit(enc_br(1'b1, 3'd3, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_imm(4'h7, 5'd16, 8'h0F));           // ANDI
        emit(enc_br(1'b0, 3'd4, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_imm(4'h6, 5'd18, 8'h81));           // ORI
        emit(enc_br(1'b1, 3'd5, 7'd1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_mem(1'b1, 5'd18, 1'b1));
        emit(enc_ldi(5'd26, 8'h00));
        emit(enc_ldi(5'd27, 8'h02));                 // Loads from 0x0200
        emit(enc_mem(1'b0, 5'd20, 1'b1));
        emit(enc_mem(1'b0, 5'd21, 1'b1));
        emit(enc_rr(6'b000011, 5'd20, 5'd21));
        emit(enc_mem(1'b1, 5'd20, 1'b1));
        emit(enc_mem(1'b1, 5'd21, 1'b0));
        emit(enc_rjmp(12'd1));                       // Skips the next store
        emit(enc_mem(1'b1, 5'd16, 1'b1));
        emit(enc_mem(1'b1, 5'd19, 1'b1));
        emit(enc_rjmp(12'hFFF));
    endtask

    initial begin
        int wait_cnt;
        reset_n     = 1'b0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        resp_state  = 0;
        resp_cnt    = 0;
        for (int i = 0; i < 256; i++)
            rom[i] = 16'h0000;
        for (int a = 0; a < 65536; a++)
            data_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3C;
        build_program();
        run_model();

        repeat (4) @(posedge clock);
        @(negedge clock);
        check_value("pc_o", pc_o, RESET_VECTOR);
        check_value("mem_req_o", {15'd0, mem_req_o}, 16'h0000);
        check_value("mem_we_o", {15'd0, mem_we_o}, 16'h0000);
        reset_n = 1'b1;

        for (int n = 0; n < exp_addr.size(); n++) begin
            wait_cnt = 0;
            while (obs_addr.size() == 0) begin
                @(posedge clock);
                wait_cnt++;
                if (wait_cnt > 500) begin
                    $display("Timeout: store number %0d never reached data memory", n);
                    $display("Simulation failed");
                    $fatal(1);
                end
            end
            check_value("mem_addr_o", obs_addr.pop_front(), exp_addr[n]);
            check_value("mem_wdata_o", {8'h00, obs_data.pop_front()}, {8'h00, exp_data[n]});
        end

        // Idle loop must stay quiet
        repeat (50) @(posedge clock);
        check_value("extra_store_count", 16'(obs_addr.size()), 16'h0000);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
